// ==== Makefile ====
# Verilator flow for the stopwatch project
#   make lint   lint the design with all warnings on
#   make sim    build and run the testbench, pass only if the log says so
#   make clean  remove build products and the log

TB_TOP  = tb_stopwatch
SIM_LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module stopwatch_top -f flist.f

# Warnings are still printed, they just do not stop the build
sim:
	rm -f $(SIM_LOG)
	verilator --binary --timing -Wno-fatal --top-module $(TB_TOP) \
		-f flist.f -o $(TB_TOP)_sim
	./obj_dir/$(TB_TOP)_sim | tee $(SIM_LOG)
	@if grep -q "TEST RESULT: PASS" $(SIM_LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(SIM_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== flist.f ====
stopwatch_pkg.sv
stopwatch_counter.sv
hex_to_sseg.sv
sseg_scan_mux.sv
stopwatch_top.sv
tb_stopwatch.sv

// ==== hex_to_sseg.sv ====
// Combinational 4-bit to active-low seven-segment decoder, decimal point left off
module hex_to_sseg
    (
        input  logic [stopwatch_pkg::DIGIT_W-1:0] i_hex,
        output logic [stopwatch_pkg::SSEG_W-1:0]  o_sseg_n
    );

    import stopwatch_pkg::*;

    // Bit order dp g f e d c b a, zero lights a segment
    // Top bit stays 1 so dp is dark
    always_comb
    begin
        case (i_hex)
            4'h0: o_sseg_n = 8'b1100_0000;
            4'h1: o_sseg_n = 8'b1111_1001;
            4'h2: o_sseg_n = 8'b1010_0100;
            4'h3: o_sseg_n = 8'b1011_0000;
            4'h4: o_sseg_n = 8'b1001_1001;
            4'h5: o_sseg_n = 8'b1001_0010;
            4'h6: o_sseg_n = 8'b1000_0010;
            4'h7: o_sseg_n = 8'b1111_1000;
            4'h8: o_sseg_n = 8'b1000_0000;
            4'h9: o_sseg_n = 8'b1001_0000;
            // Letters A b C d E F
            4'hA: o_sseg_n = 8'b1000_1000;
            4'hB: o_sseg_n = 8'b1000_0011;
            4'hC: o_sseg_n = 8'b1100_0110;
            4'hD: o_sseg_n = 8'b1010_0001;
            4'hE: o_sseg_n = 8'b1000_0110;
            4'hF: o_sseg_n = 8'b1000_1110;
            // Blank
            default: o_sseg_n = {SSEG_W{1'b1}};
        endcase
    end

endmodule

// ==== sseg_scan_mux.sv ====
// Four-digit display scanner; steps a one-hot select and registers the matching segments
module sseg_scan_mux
    #(
        parameter int unsigned SCAN_DIV = stopwatch_pkg::SCAN_DIV_DEFAULT
    )
    (
        input  logic                                 clk,
        input  logic                                 i_rst,
        input  logic [stopwatch_pkg::SSEG_W-1:0]     i_digit0_n,
        input  logic [stopwatch_pkg::SSEG_W-1:0]     i_digit1_n,
        input  logic [stopwatch_pkg::SSEG_W-1:0]     i_digit2_n,
        input  logic [stopwatch_pkg::SSEG_W-1:0]     i_digit3_n,
        output logic [stopwatch_pkg::SSEG_W-1:0]     o_sseg_n,
        output logic [stopwatch_pkg::NUM_DIGITS-1:0] o_ldsel
    );

    import stopwatch_pkg::*;

    // Scan prescaler width, at least one bit
    localparam int unsigned SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [SCAN_W-1:0] r_scan_cnt;
    logic [POS_W-1:0]  r_pos;
    logic              w_step;
    logic [POS_W-1:0]  w_pos_next;
    logic [POS_W-1:0]  w_pos_load;
    logic [SSEG_W-1:0] w_pat_n [NUM_DIGITS];
    logic [SSEG_W-1:0] w_seg_next_n;

    // Patterns by position
    assign w_pat_n[0] = i_digit0_n;
    assign w_pat_n[1] = i_digit1_n;
    assign w_pat_n[2] = i_digit2_n;
    assign w_pat_n[3] = i_digit3_n;

    // Move to the next position at the end of each slot
    assign w_step     = (r_scan_cnt == SCAN_W'(SCAN_DIV - 1));
    assign w_pos_next = w_step ? r_pos + 1'b1 : r_pos;

    // Position whose pattern gets loaded, 0 during reset
    assign w_pos_load = i_rst ? '0 : w_pos_next;

    // Selected pattern with dp forced on where the mask says so
    always_comb
    begin
        w_seg_next_n = w_pat_n[w_pos_load];
        if (DP_MASK[w_pos_load])
            w_seg_next_n[SSEG_W-1] = 1'b0;
    end

    // Slot counter, position index and digit select
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_scan_cnt <= '0;
            r_pos      <= '0;
            o_ldsel    <= NUM_DIGITS'(1);
        end
        else
        begin
            if (w_step)
                r_scan_cnt <= '0;
            else
                r_scan_cnt <= r_scan_cnt + 1'b1;
            r_pos   <= w_pos_next;
            // Select and segments switch together
            o_ldsel <= NUM_DIGITS'(1) << w_pos_next;
        end
    end

    // Segments follow the digit inputs every cycle
    always_ff @(posedge clk)
    begin
        o_sseg_n <= w_seg_next_n;
    end

endmodule

// ==== stopwatch_counter.sv ====
// Tenth-second prescaler and cascaded BCD digits (M:SS.T); counts while i_go is high
module stopwatch_counter
    #(
        parameter int unsigned TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT
    )
    (
        input  logic                              clk,
        input  logic                              i_rst,
        input  logic                              i_go,
        output logic [stopwatch_pkg::DIGIT_W-1:0] o_tenths,
        output logic [stopwatch_pkg::DIGIT_W-1:0] o_sec_units,
        output logic [stopwatch_pkg::DIGIT_W-1:0] o_sec_tens,
        output logic [stopwatch_pkg::DIGIT_W-1:0] o_minutes
    );

    import stopwatch_pkg::*;

    // Prescaler width, at least one bit
    localparam int unsigned TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [TICK_W-1:0] r_tick_cnt;
    logic              w_tick;
    logic              w_carry_tenths;
    logic              w_carry_units;
    logic              w_carry_tens;

    // Tick fires on the last prescaler count, only while running
    assign w_tick = i_go && (r_tick_cnt == TICK_W'(TICK_DIV - 1));

    // Carry chain
    // Each stage needs the tick and every lower digit at its top value
    assign w_carry_tenths = w_tick && (o_tenths == DEC_MAX);
    assign w_carry_units  = w_carry_tenths && (o_sec_units == DEC_MAX);
    assign w_carry_tens   = w_carry_units && (o_sec_tens == SEC_TENS_MAX);

    // Prescaler holds its partial count while paused
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_tick_cnt <= '0;
        end
        else if (i_go)
        begin
            if (w_tick)
                r_tick_cnt <= '0;
            else
                r_tick_cnt <= r_tick_cnt + 1'b1;
        end
    end

    // Tenths, 0..9
    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_tenths <= '0;
        else if (w_tick)
            o_tenths <= w_carry_tenths ? '0 : o_tenths + 1'b1;
    end

    // Seconds units, 0..9
    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_sec_units <= '0;
        else if (w_carry_tenths)
            o_sec_units <= w_carry_units ? '0 : o_sec_units + 1'b1;
    end

    // Seconds tens, 0..5
    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_sec_tens <= '0;
        else if (w_carry_units)
            o_sec_tens <= w_carry_tens ? '0 : o_sec_tens + 1'b1;
    end

    // Minutes, 0..9
    // 9:59.9 wraps the whole watch back to 0:00.0
    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_minutes <= '0;
        else if (w_carry_tens)
            o_minutes <= (o_minutes == DEC_MAX) ? '0 : o_minutes + 1'b1;
    end

endmodule

// ==== stopwatch_pkg.sv ====
// Shared constants for the stopwatch design; modules pull them in with a wildcard import
package stopwatch_pkg;

    // Segment pattern, top bit down: dp g f e d c b a
    // All segment lines are active low
    localparam int unsigned SSEG_W = 8;

    // Display positions on the socket
    localparam int unsigned NUM_DIGITS = 4;

    // Scan position index width
    localparam int unsigned POS_W = $clog2(NUM_DIGITS);

    // One BCD digit
    localparam int unsigned DIGIT_W = 4;

    // Rollover values of the BCD counters
    // Tenths, seconds units and minutes run 0..9
    localparam logic [DIGIT_W-1:0] DEC_MAX = 4'd9;

    // Seconds tens run 0..5
    localparam logic [DIGIT_W-1:0] SEC_TENS_MAX = 4'd5;

    // 100 MHz clk, one tick per tenth of a second
    localparam int unsigned TICK_DIV_DEFAULT = 10_000_000;

    // Cycles each digit stays lit
    // 100 MHz / 65536 / 4 digits, roughly 380 Hz per digit
    localparam int unsigned SCAN_DIV_DEFAULT = 65_536;

    // Decimal point per position, set bit lights it
    // Bits 1 and 3 give the M:SS.T punctuation
    localparam logic [NUM_DIGITS-1:0] DP_MASK = 4'b1010;

    // Board adjustable supply
    // Select code for 1.8 V
    localparam logic [1:0] VADJ_SEL = 2'b01;

    // Supply regulator enable
    localparam logic VADJ_ENABLE = 1'b1;

endpackage

// ==== stopwatch_top.sv ====
// Stopwatch top level: counter, four digit decoders, display scanner and board supply select
module stopwatch_top
    #(
        parameter int unsigned TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT,
        parameter int unsigned SCAN_DIV = stopwatch_pkg::SCAN_DIV_DEFAULT
    )
    (
        input  logic                                 clk,
        input  logic                                 i_rst,
        input  logic                                 i_go,
        output logic [stopwatch_pkg::SSEG_W-1:0]     o_sseg_n,
        output logic [stopwatch_pkg::NUM_DIGITS-1:0] o_ldsel,
        output logic [1:0]                           o_set_vadj,
        output logic                                 o_vadj_en
    );

    import stopwatch_pkg::*;

    // BCD digits
    logic [DIGIT_W-1:0] w_tenths;
    logic [DIGIT_W-1:0] w_sec_units;
    logic [DIGIT_W-1:0] w_sec_tens;
    logic [DIGIT_W-1:0] w_minutes;

    // Decoded patterns, one per display position
    logic [SSEG_W-1:0] w_seg0_n;
    logic [SSEG_W-1:0] w_seg1_n;
    logic [SSEG_W-1:0] w_seg2_n;
    logic [SSEG_W-1:0] w_seg3_n;

    // Socket runs from the 1.8 V rail
    assign o_set_vadj = VADJ_SEL;
    assign o_vadj_en  = VADJ_ENABLE;

    stopwatch_counter #(
        .TICK_DIV (TICK_DIV)
    ) u_counter (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_go        (i_go),
        .o_tenths    (w_tenths),
        .o_sec_units (w_sec_units),
        .o_sec_tens  (w_sec_tens),
        .o_minutes   (w_minutes)
    );

    // Position 0 is the rightmost digit, tenths
    hex_to_sseg u_hex_to_sseg_0 (
        .i_hex    (w_tenths),
        .o_sseg_n (w_seg0_n)
    );

    hex_to_sseg u_hex_to_sseg_1 (
        .i_hex    (w_sec_units),
        .o_sseg_n (w_seg1_n)
    );

    hex_to_sseg u_hex_to_sseg_2 (
        .i_hex    (w_sec_tens),
        .o_sseg_n (w_seg2_n)
    );

    // Leftmost digit, minutes
    hex_to_sseg u_hex_to_sseg_3 (
        .i_hex    (w_minutes),
        .o_sseg_n (w_seg3_n)
    );

    sseg_scan_mux #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan_mux (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_digit0_n (w_seg0_n),
        .i_digit1_n (w_seg1_n),
        .i_digit2_n (w_seg2_n),
        .i_digit3_n (w_seg3_n),
        .o_sseg_n   (o_sseg_n),
        .o_ldsel    (o_ldsel)
    );

endmodule

// ==== tb_stopwatch.sv ====
// Self-checking testbench for stopwatch_top; runs the scenario list and prints per-test results
module tb_stopwatch;

    import stopwatch_pkg::*;

    // Shortened divisors so a tenth lasts 4 cycles and a slot 3 cycles
    localparam int TICK_DIV    = 4;
    localparam int SCAN_DIV    = 3;
    localparam int SETTLE      = NUM_DIGITS * SCAN_DIV + 2;
    localparam int SLOT_LIMIT  = 2 * NUM_DIGITS * SCAN_DIV + 4;
    localparam int ACK_LIMIT   = 10;
    localparam int SCAN_ROUNDS = 3;

    logic                  clk;
    logic                  i_rst;
    logic                  i_go;
    logic [SSEG_W-1:0]     o_sseg_n;
    logic [NUM_DIGITS-1:0] o_ldsel;
    logic [1:0]            o_set_vadj;
    logic                  o_vadj_en;

    // Model state and bookkeeping
    logic [31:0]           lfsr_state;
    int                    go_cycles;
    int                    main_errors;
    int                    compare_errors;
    int                    errs_at_start;
    int                    tests_passed;
    int                    tests_failed;

    // Sampler to comparer exchange
    logic [SSEG_W-1:0]     seen_n [NUM_DIGITS];
    logic [NUM_DIGITS-1:0] seen_valid;
    logic [SSEG_W-1:0]     cmp_exp_n;
    int                    exp_tenths;
    int                    check_req;
    int                    check_ack;

    stopwatch_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) dut (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_go       (i_go),
        .o_sseg_n   (o_sseg_n),
        .o_ldsel    (o_ldsel),
        .o_set_vadj (o_set_vadj),
        .o_vadj_en  (o_vadj_en)
    );

    always #5 clk = ~clk;

    // Go cycles seen by the DUT since the last reset
    always @(posedge clk)
    begin
        if (i_rst)
            go_cycles = 0;
        else if (i_go)
            go_cycles = go_cycles + 1;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // Expected active-low pattern at one position for a tenths count
    function automatic logic [SSEG_W-1:0] ref_pattern(input int tenths, input int pos);
        int         v;
        int         d;
        logic [6:0] lit;
        v = tenths % 6000;
        case (pos)
            0:       d = v % 10;
            1:       d = (v / 10) % 10;
            2:       d = (v / 100) % 6;
            default: d = v / 600;
        endcase
        // Lit segments active high in bit order g f e d c b a
        case (d)
            0:       lit = 7'h3F;
            1:       lit = 7'h06;
            2:       lit = 7'h5B;
            3:       lit = 7'h4F;
            4:       lit = 7'h66;
            5:       lit = 7'h6D;
            6:       lit = 7'h7D;
            7:       lit = 7'h07;
            8:       lit = 7'h7F;
            default: lit = 7'h6F;
        endcase
        return {~DP_MASK[pos], ~lit};
    endfunction

    // Next absolute tenths value above the current one that shows checkpoint c
    function automatic int next_target(input int cur_tenths, input int c);
        int t;
        t = (cur_tenths / 6000) * 6000 + c;
        if (t <= cur_tenths)
            t = t + 6000;
        return t;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Starts on a falling edge and drops i_go after exactly n go cycles
    task automatic run_go(input int n);
        i_go = 1'b1;
        repeat (n) @(negedge clk);
        i_go = 1'b0;
    endtask

    task automatic check_onehot();
        if ($countones(o_ldsel) != 1)
        begin
            $display("[FAIL] t=%0t o_ldsel expected one-hot got %b", $time, o_ldsel);
            main_errors++;
        end
    endtask

    // Sampler records each position's pattern as it comes up on the scan
    task automatic capture_display();
        int guard;
        seen_valid = '0;
        for (int p = 0; p < NUM_DIGITS; p++)
        begin
            guard = 0;
            check_onehot();
            while (o_ldsel !== (4'b0001 << p) && guard < SLOT_LIMIT)
            begin
                @(negedge clk);
                check_onehot();
                guard++;
            end
            if (o_ldsel === (4'b0001 << p))
            begin
                seen_n[p]     = o_sseg_n;
                seen_valid[p] = 1'b1;
            end
        end
    endtask

    // Idle, sample all four positions, then hand them to the comparer
    task automatic verify_display(input int tenths);
        int guard;
        repeat (SETTLE) @(negedge clk);
        capture_display();
        exp_tenths = tenths;
        check_req++;
        guard = 0;
        while (check_ack != check_req && guard < ACK_LIMIT)
        begin
            @(negedge clk);
            guard++;
        end
        if (check_ack != check_req)
        begin
            $display("Comparer gave no answer within %0d cycles at t=%0t", ACK_LIMIT, $time);
            main_errors++;
        end
    endtask

    task automatic close_test(input int num, input string name);
        int now_errs;
        now_errs = main_errors + compare_errors;
        if (now_errs == errs_at_start)
        begin
            $display("test %0d %s: ok", num, name);
            tests_passed++;
        end
        else
        begin
            $display("test %0d %s: %0d errors", num, name, now_errs - errs_at_start);
            tests_failed++;
        end
        errs_at_start = now_errs;
    endtask

    // Comparer works off the last captured display
    always @(posedge clk)
    begin
        if (check_ack != check_req)
        begin
            for (int p = 0; p < NUM_DIGITS; p++)
            begin
                cmp_exp_n = ref_pattern(exp_tenths, p);
                if (!seen_valid[p])
                begin
                    $display("Position %0d was never selected before the timeout at t=%0t",
                             p, $time);
                    compare_errors++;
                end
                else if (seen_n[p] !== cmp_exp_n)
                begin
                    $display("[FAIL] t=%0t o_sseg_n pos %0d expected %b got %b",
                             $time, p, cmp_exp_n, seen_n[p]);
                    compare_errors++;
                end
            end
            check_ack = check_req;
        end
    end

    initial
    begin
        int                    r;
        int                    n;
        int                    t;
        int                    guard;
        int                    changes;
        int                    checkpoints [7];
        logic [NUM_DIGITS-1:0] prev_sel;
        logic [NUM_DIGITS-1:0] exp_sel;

        clk            = 1'b0;
        i_rst          = 1'b1;
        i_go           = 1'b0;
        lfsr_state     = 32'h4bb8dcc4;
        go_cycles      = 0;
        main_errors    = 0;
        compare_errors = 0;
        errs_at_start  = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        check_req      = 0;
        check_ack      = 0;
        exp_tenths     = 0;
        seen_valid     = '0;
        checkpoints    = '{99, 100, 599, 600, 5999, 0, 1};

        // Test 1 covers the reset state
        repeat (16) @(negedge clk);
        if (o_ldsel !== 4'b0001)
        begin
            $display("[FAIL] t=%0t o_ldsel expected %b got %b", $time, 4'b0001, o_ldsel);
            main_errors++;
        end
        if (o_sseg_n !== ref_pattern(0, 0))
        begin
            $display("[FAIL] t=%0t o_sseg_n expected %b got %b",
                     $time, ref_pattern(0, 0), o_sseg_n);
            main_errors++;
        end
        i_rst = 1'b0;
        if (o_vadj_en !== 1'b1)
        begin
            $display("[FAIL] t=%0t o_vadj_en expected %b got %b", $time, 1'b1, o_vadj_en);
            main_errors++;
        end
        if (o_set_vadj !== VADJ_SEL)
        begin
            $display("[FAIL] t=%0t o_set_vadj expected %b got %b", $time, VADJ_SEL, o_set_vadj);
            main_errors++;
        end
        verify_display(0);
        close_test(1, "reset state");

        // Test 2 makes one long run of 100 to 900 go cycles
        draw_bits(10, r);
        n = 100 + r % 801;
        run_go(n);
        verify_display(go_cycles / TICK_DIV);
        close_test(2, "counting");

        // Test 3 bursts always end mid-count so the prescaler holds a partial count
        for (int b = 0; b < 4; b++)
        begin
            draw_bits(6, r);
            n = 10 + r;
            if ((go_cycles + n) % TICK_DIV == 0)
                n++;
            run_go(n);
            draw_bits(5, r);
            repeat (5 + r) @(negedge clk);
            verify_display(go_cycles / TICK_DIV);
        end
        close_test(3, "pause and resume");

        // Test 4 lands on each side of every rollover
        foreach (checkpoints[k])
        begin
            t = next_target(go_cycles / TICK_DIV, checkpoints[k]);
            draw_bits(2, r);
            run_go(t * TICK_DIV + r % TICK_DIV - go_cycles);
            verify_display(go_cycles / TICK_DIV);
        end
        close_test(4, "carry chain");

        // Test 5 resets while i_go is high
        draw_bits(6, r);
        i_go = 1'b1;
        repeat (30 + r) @(negedge clk);
        i_rst = 1'b1;
        repeat (16) @(negedge clk);
        i_rst = 1'b0;
        i_go  = 1'b0;
        verify_display(0);
        draw_bits(6, r);
        run_go(40 + r);
        verify_display(go_cycles / TICK_DIV);
        close_test(5, "reset mid-count");

        // Test 6 expects each select change to be a rotate left by one
        @(negedge clk);
        prev_sel = o_ldsel;
        changes  = 0;
        guard    = 0;
        while (changes < SCAN_ROUNDS * NUM_DIGITS && guard < SCAN_ROUNDS * SLOT_LIMIT)
        begin
            @(negedge clk);
            guard++;
            check_onehot();
            if (o_ldsel !== prev_sel)
            begin
                exp_sel = {prev_sel[NUM_DIGITS-2:0], prev_sel[NUM_DIGITS-1]};
                if (o_ldsel !== exp_sel)
                begin
                    $display("[FAIL] t=%0t o_ldsel expected %b got %b", $time, exp_sel, o_ldsel);
                    main_errors++;
                end
                changes++;
                prev_sel = o_ldsel;
            end
        end
        if (changes < SCAN_ROUNDS * NUM_DIGITS)
        begin
            $display("Scan stalled, only %0d select changes before the timeout", changes);
            main_errors++;
        end
        close_test(6, "scan order");

        $display("tests passed %0d failed %0d, failed checks %0d",
                 tests_passed, tests_failed, main_errors + compare_errors);
        if (tests_failed == 0 && main_errors + compare_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
